/* hdl/exe_pkg.sv */
package exe_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    // add and sub trap on signed overflow
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        hilo_none,
        hilo_mult,
        hilo_multu,
        hilo_mthi,
        hilo_mtlo,
        hilo_mfhi,
        hilo_mflo
    } hilo_op_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_t;

    // same encoding as the sram size field
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        ex_none,
        ex_ov,
        ex_adel,
        ex_ades
    } ex_code_t;

endpackage

/* hdl/exe_alu.sv */
`timescale 1ns/1ps

module exe_alu import exe_pkg::*; (
    input  alu_op_t           r_alu_op,
    input  logic              r_src1_is_sa,
    input  logic              r_src1_is_pc,
    input  logic              r_src2_is_imm,
    input  logic              r_src2_is_uimm,
    input  logic              r_src2_is_8,
    input  logic [15:0]       r_imm,
    input  logic [word_w-1:0] r_pc,
    input  logic [word_w-1:0] r_rs_value,
    input  logic [word_w-1:0] r_rt_value,
    output logic [word_w-1:0] alu_result,
    output logic              alu_ov
);

    logic [word_w-1:0] src1;
    logic [word_w-1:0] src2;
    logic [word_w-1:0] sum;
    logic [word_w-1:0] diff;
    logic [4:0]        shamt;
    logic              add_ov;
    logic              sub_ov;

    // sa field sits in imm[10:6]
    assign src1 = r_src1_is_sa ? {27'b0, r_imm[10:6]} :
                  r_src1_is_pc ? r_pc :
                                 r_rs_value;

    assign src2 = r_src2_is_uimm ? {16'b0, r_imm} :
                  r_src2_is_imm  ? {{16{r_imm[15]}}, r_imm} :
                  r_src2_is_8    ? 32'd8 :
                                   r_rt_value;

    assign sum   = src1 + src2;
    assign diff  = src1 - src2;
    assign shamt = src1[4:0];

    // same-sign inputs, flipped result sign
    assign add_ov = (src1[31] == src2[31]) && (sum[31] != src1[31]);
    assign sub_ov = (src1[31] != src2[31]) && (diff[31] != src1[31]);

    always_comb begin
        case (r_alu_op)
            alu_add:  alu_result = sum;
            alu_sub:  alu_result = diff;
            alu_slt:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: alu_result = {31'b0, src1 < src2};
            alu_and:  alu_result = src1 & src2;
            alu_or:   alu_result = src1 | src2;
            alu_xor:  alu_result = src1 ^ src2;
            alu_nor:  alu_result = ~(src1 | src2);
            alu_sll:  alu_result = src2 << shamt;
            alu_srl:  alu_result = src2 >> shamt;
            alu_sra:  alu_result = $signed(src2) >>> shamt;
            alu_lui:  alu_result = {r_imm, 16'b0};
            default:  alu_result = '0;
        endcase
    end

    assign alu_ov = ((r_alu_op == alu_add) && add_ov) ||
                    ((r_alu_op == alu_sub) && sub_ov);

endmodule

/* hdl/hilo_unit.sv */
`timescale 1ns/1ps

module hilo_unit import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  hilo_op_t          r_hilo_op,
    input  logic [word_w-1:0] r_rs_value,
    input  logic [word_w-1:0] r_rt_value,
    input  logic [word_w-1:0] alu_result,
    output logic [word_w-1:0] result
);

    logic [word_w-1:0]   hi;
    logic [word_w-1:0]   lo;
    logic                is_signed;
    logic signed [32:0]  mul_a;
    logic signed [32:0]  mul_b;
    logic signed [65:0]  product;

    // one 33x33 signed multiplier covers both mult and multu
    assign is_signed = (r_hilo_op == hilo_mult);
    assign mul_a     = {is_signed & r_rs_value[31], r_rs_value};
    assign mul_b     = {is_signed & r_rt_value[31], r_rt_value};
    assign product   = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (r_hilo_op)
                hilo_mult,
                hilo_multu: begin
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
                hilo_mthi: hi <= r_rs_value;
                hilo_mtlo: lo <= r_rs_value;
                default: ;
            endcase
        end
    end

    assign result = (r_hilo_op == hilo_mfhi) ? hi :
                    (r_hilo_op == hilo_mflo) ? lo :
                                               alu_result;

endmodule

/* hdl/mem_align.sv */
`timescale 1ns/1ps

module mem_align import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  mem_op_t           r_mem_op,
    input  mem_size_t         r_mem_size,
    input  logic              r_mem_unsigned,
    input  logic [word_w-1:0] r_rt_value,
    input  logic [word_w-1:0] alu_result,
    output logic              adr_err,
    output mem_size_t         req_size,
    output logic [3:0]        wstrb,
    output logic [word_w-1:0] wdata
);

    logic [1:0] offset;
    logic       is_store;

    assign offset   = alu_result[1:0];
    assign is_store = (r_mem_op == mem_store);
    assign req_size = r_mem_size;

    assign adr_err = (r_mem_op != mem_none) &&
                     (((r_mem_size == size_half) && offset[0]) ||
                      ((r_mem_size == size_word) && (offset != 2'b00)));

    always_comb begin
        wstrb = 4'b0000;
        if (is_store && !adr_err) begin
            case (r_mem_size)
                size_byte: wstrb = 4'b0001 << offset;
                size_half: wstrb = offset[1] ? 4'b1100 : 4'b0011;
                size_word: wstrb = 4'b1111;
                default:   wstrb = 4'b0000;
            endcase
        end
    end

    // replicate so every lane carries the store data
    always_comb begin
        case (r_mem_size)
            size_byte: wdata = {4{r_rt_value[7:0]}};
            size_half: wdata = {2{r_rt_value[15:0]}};
            default:   wdata = r_rt_value;
        endcase
    end

    // zero extension only applies to lbu and lhu
    assert property (@(posedge clk) disable iff (reset)
        r_mem_unsigned && (r_mem_op != mem_none) |->
            (r_mem_op == mem_load) && (r_mem_size != size_word));

endmodule

/* hdl/exe_ctrl.sv */
`timescale 1ns/1ps

module exe_ctrl import exe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  alu_op_t               alu_op,
    input  logic                  src1_is_sa,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  logic                  src2_is_uimm,
    input  logic                  src2_is_8,
    input  hilo_op_t              hilo_op,
    input  mem_op_t               mem_op,
    input  mem_size_t             mem_size,
    input  logic                  mem_unsigned,
    input  logic                  gr_we,
    input  logic [reg_addr_w-1:0] dest,
    input  logic [15:0]           imm,
    input  logic [word_w-1:0]     pc,
    input  logic [word_w-1:0]     rs_value,
    input  logic [word_w-1:0]     rt_value,
    input  logic                  out_ready,
    input  logic                  data_sram_addr_ok,
    input  logic                  alu_ov,
    input  logic                  adr_err,
    input  logic [word_w-1:0]     result,
    output alu_op_t               r_alu_op,
    output logic                  r_src1_is_sa,
    output logic                  r_src1_is_pc,
    output logic                  r_src2_is_imm,
    output logic                  r_src2_is_uimm,
    output logic                  r_src2_is_8,
    output hilo_op_t              r_hilo_op,
    output mem_op_t               r_mem_op,
    output mem_size_t             r_mem_size,
    output logic                  r_mem_unsigned,
    output logic [15:0]           r_imm,
    output logic [word_w-1:0]     r_pc,
    output logic [word_w-1:0]     r_rs_value,
    output logic [word_w-1:0]     r_rt_value,
    output logic                  commit,
    output logic                  data_sram_en,
    output logic                  out_valid,
    output logic [word_w-1:0]     out_pc,
    output logic [reg_addr_w-1:0] out_dest,
    output logic                  out_gr_we,
    output logic [word_w-1:0]     out_result,
    output mem_op_t               out_mem_op,
    output ex_code_t              out_ex_code
);

    logic valid;
    logic sent;
    logic ready_go;
    logic take;

    assign take = in_valid && in_ready;

    // one request per memory instruction, none on a fault
    assign data_sram_en = valid && (r_mem_op != mem_none) && !adr_err && !alu_ov && !sent;
    assign ready_go     = !data_sram_en || data_sram_addr_ok;
    assign out_valid    = valid && ready_go;
    assign in_ready     = !valid || (ready_go && out_ready);
    assign commit       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            sent  <= 1'b0;
        end else begin
            if (in_ready) begin
                valid <= in_valid;
            end
            if (commit) begin
                sent <= 1'b0;
            end else if (data_sram_en && data_sram_addr_ok) begin
                sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_mem_op  <= mem_none;
            r_hilo_op <= hilo_none;
        end else if (take) begin
            r_mem_op  <= mem_op;
            r_hilo_op <= hilo_op;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            r_alu_op       <= alu_op;
            r_src1_is_sa   <= src1_is_sa;
            r_src1_is_pc   <= src1_is_pc;
            r_src2_is_imm  <= src2_is_imm;
            r_src2_is_uimm <= src2_is_uimm;
            r_src2_is_8    <= src2_is_8;
            r_mem_size     <= mem_size;
            r_mem_unsigned <= mem_unsigned;
            r_imm          <= imm;
            r_pc           <= pc;
            r_rs_value     <= rs_value;
            r_rt_value     <= rt_value;
            out_gr_we      <= gr_we;
            out_dest       <= dest;
        end
    end

    // overflow wins over address errors
    always_comb begin
        if (alu_ov) begin
            out_ex_code = ex_ov;
        end else if (adr_err && (r_mem_op == mem_load)) begin
            out_ex_code = ex_adel;
        end else if (adr_err && (r_mem_op == mem_store)) begin
            out_ex_code = ex_ades;
        end else begin
            out_ex_code = ex_none;
        end
    end

    assign out_pc     = r_pc;
    assign out_result = result;
    assign out_mem_op = r_mem_op;

    assert property (@(posedge clk) disable iff (reset)
        data_sram_en && !data_sram_addr_ok |=> data_sram_en);

    // held handoff keeps its payload, including hi/lo reads
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_ex_code));

endmodule

/* hdl/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // decode side
    input  logic                  in_valid,
    output logic                  in_ready,
    input  alu_op_t               alu_op,
    input  logic                  src1_is_sa,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  logic                  src2_is_uimm,
    input  logic                  src2_is_8,
    input  hilo_op_t              hilo_op,
    input  mem_op_t               mem_op,
    input  mem_size_t             mem_size,
    input  logic                  mem_unsigned,
    input  logic                  gr_we,
    input  logic [reg_addr_w-1:0] dest,
    input  logic [15:0]           imm,
    input  logic [word_w-1:0]     pc,
    input  logic [word_w-1:0]     rs_value,
    input  logic [word_w-1:0]     rt_value,
    // memory stage side
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [word_w-1:0]     out_pc,
    output logic [reg_addr_w-1:0] out_dest,
    output logic                  out_gr_we,
    output logic [word_w-1:0]     out_result,
    output mem_op_t               out_mem_op,
    output ex_code_t              out_ex_code,
    // data sram request
    output logic                  data_sram_en,
    output logic                  data_sram_wr,
    output mem_size_t             data_sram_size,
    output logic [3:0]            data_sram_wstrb,
    output logic [word_w-1:0]     data_sram_addr,
    output logic [word_w-1:0]     data_sram_wdata,
    input  logic                  data_sram_addr_ok
);

    alu_op_t               r_alu_op;
    logic                  r_src1_is_sa;
    logic                  r_src1_is_pc;
    logic                  r_src2_is_imm;
    logic                  r_src2_is_uimm;
    logic                  r_src2_is_8;
    hilo_op_t              r_hilo_op;
    mem_op_t               r_mem_op;
    mem_size_t             r_mem_size;
    logic                  r_mem_unsigned;
    logic [15:0]           r_imm;
    logic [word_w-1:0]     r_pc;
    logic [word_w-1:0]     r_rs_value;
    logic [word_w-1:0]     r_rt_value;
    logic [word_w-1:0]     alu_result;
    logic                  alu_ov;
    logic                  adr_err;
    logic [word_w-1:0]     result;
    logic                  commit;

    assign data_sram_addr = alu_result;
    assign data_sram_wr   = (r_mem_op == mem_store);

    exe_ctrl i_ctrl (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .alu_op            (alu_op),
        .src1_is_sa        (src1_is_sa),
        .src1_is_pc        (src1_is_pc),
        .src2_is_imm       (src2_is_imm),
        .src2_is_uimm      (src2_is_uimm),
        .src2_is_8         (src2_is_8),
        .hilo_op           (hilo_op),
        .mem_op            (mem_op),
        .mem_size          (mem_size),
        .mem_unsigned      (mem_unsigned),
        .gr_we             (gr_we),
        .dest              (dest),
        .imm               (imm),
        .pc                (pc),
        .rs_value          (rs_value),
        .rt_value          (rt_value),
        .out_ready         (out_ready),
        .data_sram_addr_ok (data_sram_addr_ok),
        .alu_ov            (alu_ov),
        .adr_err           (adr_err),
        .result            (result),
        .r_alu_op          (r_alu_op),
        .r_src1_is_sa      (r_src1_is_sa),
        .r_src1_is_pc      (r_src1_is_pc),
        .r_src2_is_imm     (r_src2_is_imm),
        .r_src2_is_uimm    (r_src2_is_uimm),
        .r_src2_is_8       (r_src2_is_8),
        .r_hilo_op         (r_hilo_op),
        .r_mem_op          (r_mem_op),
        .r_mem_size        (r_mem_size),
        .r_mem_unsigned    (r_mem_unsigned),
        .r_imm             (r_imm),
        .r_pc              (r_pc),
        .r_rs_value        (r_rs_value),
        .r_rt_value        (r_rt_value),
        .commit            (commit),
        .data_sram_en      (data_sram_en),
        .out_valid         (out_valid),
        .out_pc            (out_pc),
        .out_dest          (out_dest),
        .out_gr_we         (out_gr_we),
        .out_result        (out_result),
        .out_mem_op        (out_mem_op),
        .out_ex_code       (out_ex_code)
    );

    exe_alu i_alu (
        .r_alu_op       (r_alu_op),
        .r_src1_is_sa   (r_src1_is_sa),
        .r_src1_is_pc   (r_src1_is_pc),
        .r_src2_is_imm  (r_src2_is_imm),
        .r_src2_is_uimm (r_src2_is_uimm),
        .r_src2_is_8    (r_src2_is_8),
        .r_imm          (r_imm),
        .r_pc           (r_pc),
        .r_rs_value     (r_rs_value),
        .r_rt_value     (r_rt_value),
        .alu_result     (alu_result),
        .alu_ov         (alu_ov)
    );

    hilo_unit i_hilo (
        .clk        (clk),
        .reset      (reset),
        .commit     (commit),
        .r_hilo_op  (r_hilo_op),
        .r_rs_value (r_rs_value),
        .r_rt_value (r_rt_value),
        .alu_result (alu_result),
        .result     (result)
    );

    mem_align i_align (
        .clk            (clk),
        .reset          (reset),
        .r_mem_op       (r_mem_op),
        .r_mem_size     (r_mem_size),
        .r_mem_unsigned (r_mem_unsigned),
        .r_rt_value     (r_rt_value),
        .alu_result     (alu_result),
        .adr_err        (adr_err),
        .req_size       (data_sram_size),
        .wstrb          (data_sram_wstrb),
        .wdata          (data_sram_wdata)
    );

endmodule

/* verif/tb_exe_stage.sv */
`timescale 1ns/1ps

module tb_exe_stage import exe_pkg::*; ();

    // operand select bits {sa, pc, imm, uimm, 8}
    localparam logic [4:0]  s_reg  = 5'b00000;
    localparam logic [4:0]  s_sa   = 5'b10000;
    localparam logic [4:0]  s_pc   = 5'b01000;
    localparam logic [4:0]  s_imm  = 5'b00100;
    localparam logic [4:0]  s_uimm = 5'b00010;
    localparam logic [4:0]  s_8    = 5'b00001;
    localparam logic [31:0] base   = 32'h0000_1000;
    localparam logic [31:0] st     = 32'h1122_3344;

    typedef struct packed {
        alu_op_t               alu_op;
        logic [4:0]            src;
        hilo_op_t              hilo_op;
        mem_op_t               mem_op;
        mem_size_t             mem_size;
        logic                  mem_unsigned;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [15:0]           imm;
        logic [word_w-1:0]     pc;
        logic [word_w-1:0]     rs;
        logic [word_w-1:0]     rt;
        logic [word_w-1:0]     exp_result;
        ex_code_t              exp_ex;
        logic                  exp_req;
        logic [3:0]            exp_wstrb;
        logic [word_w-1:0]     exp_wdata;
    } vec_t;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    alu_op_t alu_op;
    logic src1_is_sa;
    logic src1_is_pc;
    logic src2_is_imm;
    logic src2_is_uimm;
    logic src2_is_8;
    hilo_op_t hilo_op;
    mem_op_t mem_op;
    mem_size_t mem_size;
    logic mem_unsigned;
    logic gr_we;
    logic [reg_addr_w-1:0] dest;
    logic [15:0] imm;
    logic [word_w-1:0] pc;
    logic [word_w-1:0] rs_value;
    logic [word_w-1:0] rt_value;
    logic out_valid;
    logic out_ready;
    logic [word_w-1:0] out_pc;
    logic [reg_addr_w-1:0] out_dest;
    logic out_gr_we;
    logic [word_w-1:0] out_result;
    mem_op_t out_mem_op;
    ex_code_t out_ex_code;
    logic data_sram_en;
    logic data_sram_wr;
    mem_size_t data_sram_size;
    logic [3:0] data_sram_wstrb;
    logic [word_w-1:0] data_sram_addr;
    logic [word_w-1:0] data_sram_wdata;
    logic data_sram_addr_ok;

    vec_t table_q [64];
    int row_cnt = 0;
    int drv_idx = 0;
    int chk_idx = 0;
    int req_count = 0;
    int errors = 0;
    int checks = 0;
    logic table_done = 1'b0;
    logic [31:0] model_hi = '0;
    logic [31:0] model_lo = '0;
    logic held = 1'b0;
    logic [31:0] held_result;
    logic [31:0] held_pc;
    ex_code_t held_ex;
    int unsigned wait_cnt;

    exe_stage i_dut (.*);

    always #10 clk = ~clk;

    task automatic compare(string name, logic [31:0] got, logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    function automatic logic [31:0] next_pc();
        return 32'hbfc0_0000 + 32'(row_cnt * 4);
    endfunction

    task automatic add_row(alu_op_t op, logic [4:0] src, hilo_op_t hop, mem_op_t mop,
                           mem_size_t msize, logic uns, logic [15:0] im, logic [31:0] rs,
                           logic [31:0] rt, logic [31:0] res, ex_code_t ex,
                           logic [3:0] strb, logic [31:0] wd);
        vec_t v;
        v.alu_op       = op;
        v.src          = src;
        v.hilo_op      = hop;
        v.mem_op       = mop;
        v.mem_size     = msize;
        v.mem_unsigned = uns;
        v.gr_we        = (mop != mem_store);
        v.dest         = 5'(row_cnt);
        v.imm          = im;
        v.pc           = next_pc();
        v.rs           = rs;
        v.rt           = rt;
        v.exp_result   = res;
        v.exp_ex       = ex;
        // faulting memory instructions never reach the sram
        v.exp_req      = (mop != mem_none) && (ex == ex_none);
        v.exp_wstrb    = strb;
        v.exp_wdata    = wd;
        table_q[row_cnt] = v;
        row_cnt++;
    endtask

    task automatic alu_row(alu_op_t op, logic [4:0] src, logic [15:0] im, logic [31:0] rs,
                           logic [31:0] rt, logic [31:0] res, ex_code_t ex);
        add_row(op, src, hilo_none, mem_none, size_word, 1'b0, im, rs, rt, res, ex, 4'b0, '0);
    endtask

    // hi/lo reference kept in table order
    task automatic hilo_row(hilo_op_t hop, logic [31:0] rs, logic [31:0] rt);
        logic [63:0] prod;
        logic [31:0] res;
        logic        sx;
        sx   = (hop == hilo_mult);
        prod = {{32{sx & rs[31]}}, rs} * {{32{sx & rt[31]}}, rt};
        if (hop == hilo_mult || hop == hilo_multu) begin
            model_hi = prod[63:32];
            model_lo = prod[31:0];
        end else if (hop == hilo_mthi) begin
            model_hi = rs;
        end else if (hop == hilo_mtlo) begin
            model_lo = rs;
        end
        res = (hop == hilo_mfhi) ? model_hi : (hop == hilo_mflo) ? model_lo : (rs | rt);
        add_row(alu_or, s_reg, hop, mem_none, size_word, 1'b0, 16'h0, rs, rt, res, ex_none,
                4'b0, '0);
    endtask

    task automatic mem_row(mem_op_t mop, mem_size_t msize, logic uns, logic [31:0] rs,
                           logic [15:0] im, logic [31:0] rt, ex_code_t ex,
                           logic [3:0] strb, logic [31:0] wd);
        add_row(alu_add, s_imm, hilo_none, mop, msize, uns, im, rs, rt,
                rs + {{16{im[15]}}, im}, ex, strb, wd);
    endtask

    task automatic build_table();
        alu_row(alu_add,  s_reg, 16'h0, 32'd5, 32'd7, 32'd12, ex_none);
        alu_row(alu_sub,  s_reg, 16'h0, 32'd5, 32'd7, 32'hffff_fffe, ex_none);
        alu_row(alu_add,  s_reg, 16'h0, 32'hffff_ffff, 32'd1, 32'h0, ex_none);
        alu_row(alu_add,  s_reg, 16'h0, 32'h7fff_ffff, 32'd1, 32'h8000_0000, ex_ov);
        alu_row(alu_sub,  s_reg, 16'h0, 32'h8000_0000, 32'd1, 32'h7fff_ffff, ex_ov);
        alu_row(alu_slt,  s_reg, 16'h0, 32'hffff_ffff, 32'd1, 32'd1, ex_none);
        alu_row(alu_sltu, s_reg, 16'h0, 32'hffff_ffff, 32'd1, 32'd0, ex_none);
        alu_row(alu_and,  s_reg, 16'h0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, ex_none);
        alu_row(alu_or,   s_reg, 16'h0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0, ex_none);
        alu_row(alu_xor,  s_reg, 16'h0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, ex_none);
        alu_row(alu_nor,  s_reg, 16'h0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h000f_000f, ex_none);
        // sa of 4 and 8 in imm[10:6]
        alu_row(alu_sll,  s_sa, 16'h0100, 32'h0, 32'h0000_00f1, 32'h0000_0f10, ex_none);
        alu_row(alu_srl,  s_sa, 16'h0200, 32'h0, 32'h8000_1234, 32'h0080_0012, ex_none);
        alu_row(alu_sra,  s_reg, 16'h0, 32'd4, 32'h8000_0010, 32'hf800_0001, ex_none);
        alu_row(alu_lui,  s_uimm, 16'h1234, 32'h0, 32'h0, 32'h1234_0000, ex_none);
        alu_row(alu_add,  s_imm, 16'hfffe, 32'd10, 32'h0, 32'd8, ex_none);
        alu_row(alu_or,   s_uimm, 16'h8001, 32'h0001_0000, 32'h0, 32'h0001_8001, ex_none);
        alu_row(alu_slt,  s_imm, 16'hffff, 32'hffff_fff0, 32'h0, 32'd1, ex_none);
        alu_row(alu_sltu, s_imm, 16'hffff, 32'd5, 32'h0, 32'd1, ex_none);
        alu_row(alu_add,  s_pc | s_8, 16'h0, 32'h0, 32'h0, next_pc() + 32'd8, ex_none);

        hilo_row(hilo_mult, 32'hffff_fffe, 32'd3);
        hilo_row(hilo_mfhi, 32'h0, 32'h0);
        hilo_row(hilo_mflo, 32'h0, 32'h0);
        hilo_row(hilo_multu, 32'hffff_fffe, 32'd3);
        hilo_row(hilo_mfhi, 32'h0, 32'h0);
        hilo_row(hilo_mflo, 32'h0, 32'h0);
        hilo_row(hilo_mult, 32'h8000_0000, 32'h8000_0000);
        hilo_row(hilo_mfhi, 32'h0, 32'h0);
        hilo_row(hilo_multu, 32'hffff_ffff, 32'hffff_ffff);
        hilo_row(hilo_mflo, 32'h0, 32'h0);
        hilo_row(hilo_mthi, 32'hcafe_0001, 32'h0);
        hilo_row(hilo_mtlo, 32'h0bad_0002, 32'h0);
        hilo_row(hilo_mfhi, 32'h0, 32'h0);
        hilo_row(hilo_mflo, 32'h0, 32'h0);

        mem_row(mem_store, size_byte, 1'b0, base, 16'h0, st, ex_none, 4'b0001, 32'h4444_4444);
        mem_row(mem_store, size_byte, 1'b0, base, 16'h1, st, ex_none, 4'b0010, 32'h4444_4444);
        mem_row(mem_store, size_byte, 1'b0, base, 16'h2, st, ex_none, 4'b0100, 32'h4444_4444);
        mem_row(mem_store, size_byte, 1'b0, base, 16'h3, st, ex_none, 4'b1000, 32'h4444_4444);
        mem_row(mem_store, size_half, 1'b0, base, 16'h0, st, ex_none, 4'b0011, 32'h3344_3344);
        mem_row(mem_store, size_half, 1'b0, base, 16'h2, st, ex_none, 4'b1100, 32'h3344_3344);
        mem_row(mem_store, size_word, 1'b0, base, 16'h0, st, ex_none, 4'b1111, st);
        mem_row(mem_store, size_word, 1'b0, base, 16'h4, 32'ha5a5_5a5a, ex_none, 4'b1111,
                32'ha5a5_5a5a);
        mem_row(mem_load, size_byte, 1'b0, base, 16'h3, 32'h0, ex_none, 4'b0, '0);
        mem_row(mem_load, size_byte, 1'b1, base, 16'h1, 32'h0, ex_none, 4'b0, '0);
        mem_row(mem_load, size_half, 1'b0, base, 16'h2, 32'h0, ex_none, 4'b0, '0);
        mem_row(mem_load, size_half, 1'b1, base, 16'h0, 32'h0, ex_none, 4'b0, '0);
        mem_row(mem_load, size_word, 1'b0, base, 16'hfffc, 32'h0, ex_none, 4'b0, '0);
        mem_row(mem_load, size_half, 1'b0, base, 16'h1, 32'h0, ex_adel, 4'b0, '0);
        mem_row(mem_load, size_word, 1'b0, base, 16'h2, 32'h0, ex_adel, 4'b0, '0);
        mem_row(mem_store, size_half, 1'b0, base, 16'h3, st, ex_ades, 4'b0, '0);
        mem_row(mem_store, size_word, 1'b0, base, 16'h1, st, ex_ades, 4'b0, '0);
        // address add overflows, so the load must not go out
        mem_row(mem_load, size_word, 1'b0, 32'h7fff_fffc, 16'h4, 32'h0, ex_ov, 4'b0, '0);
    endtask

    always @(posedge clk) begin : driver
        vec_t v;
        if (!reset && (!in_valid || in_ready)) begin
            if (drv_idx < row_cnt && ($urandom % 5) != 0) begin
                v = table_q[drv_idx];
                in_valid     <= 1'b1;
                alu_op       <= v.alu_op;
                src1_is_sa   <= v.src[4];
                src1_is_pc   <= v.src[3];
                src2_is_imm  <= v.src[2];
                src2_is_uimm <= v.src[1];
                src2_is_8    <= v.src[0];
                hilo_op      <= v.hilo_op;
                mem_op       <= v.mem_op;
                mem_size     <= v.mem_size;
                mem_unsigned <= v.mem_unsigned;
                gr_we        <= v.gr_we;
                dest         <= v.dest;
                imm          <= v.imm;
                pc           <= v.pc;
                rs_value     <= v.rs;
                rt_value     <= v.rt;
                drv_idx      <= drv_idx + 1;
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            out_ready <= 1'b1;
        end else begin
            out_ready <= ($urandom % 3) != 0;
        end
    end

    // addr_ok comes 0 to 3 cycles into a request
    always @(posedge clk) begin : sram_model
        int unsigned pick;
        if (reset) begin
            wait_cnt          <= 0;
            data_sram_addr_ok <= 1'b0;
        end else if (data_sram_en && data_sram_addr_ok) begin
            pick = $urandom % 4;
            wait_cnt          <= pick;
            data_sram_addr_ok <= (pick == 0);
        end else if (data_sram_en) begin
            if (wait_cnt > 1) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                wait_cnt          <= 0;
                data_sram_addr_ok <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin : monitor
        vec_t v;
        if (!reset) begin
            v = table_q[chk_idx];
            if (held) begin
                if (!out_valid) begin
                    $display("out_valid dropped at %0t before its handoff", $time);
                    errors++;
                end
                compare("held out_result", out_result, held_result);
                compare("held out_pc", out_pc, held_pc);
                compare("held out_ex_code", 32'(out_ex_code), 32'(held_ex));
            end
            held        = out_valid && !out_ready;
            held_result = out_result;
            held_pc     = out_pc;
            held_ex     = out_ex_code;
            if (data_sram_en && data_sram_addr_ok) begin
                req_count++;
                compare("data_sram_addr", data_sram_addr, v.exp_result);
                compare("data_sram_size", 32'(data_sram_size), 32'(v.mem_size));
                compare("data_sram_wr", 32'(data_sram_wr), 32'(v.mem_op == mem_store));
                compare("data_sram_wstrb", 32'(data_sram_wstrb), 32'(v.exp_wstrb));
                if (v.mem_op == mem_store) begin
                    compare("data_sram_wdata", data_sram_wdata, v.exp_wdata);
                end
            end
            if (out_valid && out_ready) begin
                if (chk_idx >= row_cnt) begin
                    $display("handoff at %0t with every instruction already checked", $time);
                    errors++;
                end else begin
                    compare("out_result", out_result, v.exp_result);
                    compare("out_ex_code", 32'(out_ex_code), 32'(v.exp_ex));
                    compare("out_dest", 32'(out_dest), 32'(v.dest));
                    compare("out_gr_we", 32'(out_gr_we), 32'(v.gr_we));
                    compare("out_pc", out_pc, v.pc);
                    compare("out_mem_op", 32'(out_mem_op), 32'(v.mem_op));
                    compare("data_sram_wstrb", 32'(data_sram_wstrb), 32'(v.exp_wstrb));
                    if (v.exp_req && req_count == 0) begin
                        $display("instruction %0d was handed off without its SRAM request",
                                 chk_idx);
                        errors++;
                    end else begin
                        compare("request count", 32'(req_count), 32'(v.exp_req));
                    end
                    chk_idx++;
                end
                req_count = 0;
            end
        end
    end

    initial begin
        void'($urandom(26));
        clk               = 1'b0;
        reset             = 1'b1;
        in_valid          = 1'b0;
        alu_op            = alu_add;
        src1_is_sa        = 1'b0;
        src1_is_pc        = 1'b0;
        src2_is_imm       = 1'b0;
        src2_is_uimm      = 1'b0;
        src2_is_8         = 1'b0;
        hilo_op           = hilo_none;
        mem_op            = mem_none;
        mem_size          = size_word;
        mem_unsigned      = 1'b0;
        gr_we             = 1'b0;
        dest              = '0;
        imm               = '0;
        pc                = '0;
        rs_value          = '0;
        rt_value          = '0;
        out_ready         = 1'b1;
        data_sram_addr_ok = 1'b0;
        build_table();
        table_done = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        compare("out_valid", 32'(out_valid), 32'd0);
        compare("data_sram_en", 32'(data_sram_en), 32'd0);
        compare("data_sram_wstrb", 32'(data_sram_wstrb), 32'd0);
        compare("in_ready", 32'(in_ready), 32'd1);
        wait (chk_idx == row_cnt);
        // catch stray requests or handoffs
        repeat (8) @(posedge clk);
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_done);
        #((16 + row_cnt * 20) * 20);
        $display("timeout with %0d of %0d instructions handed off", chk_idx, row_cnt);
        $display("%0d errors in %0d checks", errors, checks);
        $display("Something failed");
        $finish;
    end

endmodule

/* flist.f */
hdl/exe_pkg.sv
hdl/exe_alu.sv
hdl/hilo_unit.sv
hdl/mem_align.sv
hdl/exe_ctrl.sv
hdl/exe_stage.sv
verif/tb_exe_stage.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_exe_stage
FLIST = flist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
